// File: Makefile
TOP       ?= tb_pid_controller
FLIST     ?= pid_controller.f
VERILATOR ?= verilator
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FLIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: pid_controller.f
rtl/pid_pkg.sv
rtl/dac_pkg.sv
rtl/param_regs.sv
rtl/oversample_filter.sv
rtl/pid_core.sv
rtl/output_preprocessor.sv
rtl/dac_instr_queue.sv
rtl/dac_controller.sv
rtl/pid_controller.sv
verification/tb_clock_gen.sv
verification/tb_pid_controller.sv

// File: rtl/dac_controller.sv
`timescale 1ns/1ps

module dac_controller
	import pid_pkg::*;
	import dac_pkg::*;
(
	input  logic                  clk50,
	input  logic                  reset,
	input  logic                  req_valid,
	input  logic [W_CHAN_SEL-1:0] req_chan,
	input  logic [W_DAC_DATA-1:0] req_code,
	output logic                  frame_done,
	output logic                  dac_nsync,
	output logic                  dac_sclk,
	output logic                  dac_din
);

	dac_frame_u            frame_new;  // frame for the pending request
	dac_frame_u            shreg;      // remaining bits, msb next
	logic [W_DIV_CNT-1:0]  div;        // clk50 count inside a half period
	logic [W_HALF_CNT-1:0] half;       // half sclk periods done
	logic [1:0]            gap;        // nsync high cycles still owed
	logic                  start;
	logic                  tick;       // half period boundary
	logic                  last;       // final half period ends here
	logic                  rise;       // sclk goes high, next bit out

	always_comb begin
		frame_new.f.prefix  = 4'h0;
		frame_new.f.command = DAC_CMD_WRITE_UPDATE;
		frame_new.f.address = 4'(req_chan);
		frame_new.f.data    = req_code;
		frame_new.f.feature = 4'h0;
	end

	assign start = dac_nsync && gap == '0 && req_valid;
	assign tick  = !dac_nsync && div == W_DIV_CNT'(SCLK_DIV - 1);
	assign last  = tick && half == W_HALF_CNT'(2 * W_DAC_FRAME - 1);
	assign rise  = tick && !last && !dac_sclk;

	////////////////////////////////////////////////////////////
	// frame sequencing

	always_ff @(posedge clk50) begin
		if (reset) begin
			dac_nsync  <= 1'b1;
			dac_sclk   <= 1'b0;
			dac_din    <= 1'b0;
			frame_done <= 1'b0;
			div        <= '0;
			half       <= '0;
			gap        <= '0;
		end else begin
			frame_done <= last;  // pulses with the nsync rise
			if (start) begin
				dac_nsync <= 1'b0;
				dac_sclk  <= 1'b1;  // first rising edge opens the frame
				dac_din   <= frame_new.raw[W_DAC_FRAME-1];
				div       <= '0;
				half      <= '0;
			end else if (last) begin
				dac_nsync <= 1'b1;  // sclk is already low here
				gap       <= 2'(NSYNC_GAP - 1);
			end else if (tick) begin
				div      <= '0;
				half     <= half + 1'b1;
				dac_sclk <= ~dac_sclk;
				if (rise)
					dac_din <= shreg.raw[W_DAC_FRAME-1];
			end else if (!dac_nsync) begin
				div <= div + 1'b1;
			end else if (gap != '0) begin
				gap <= gap - 1'b1;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (start)
			shreg.raw <= {frame_new.raw[W_DAC_FRAME-2:0], 1'b0};
		else if (rise)
			shreg.raw <= {shreg.raw[W_DAC_FRAME-2:0], 1'b0};
	end

	// dac latches din on the falling sclk edge
	din_stable_high: assert property (@(posedge clk50) disable iff (reset)
		$past(dac_sclk) |-> $stable(dac_din));

endmodule

// File: rtl/dac_instr_queue.sv
`timescale 1ns/1ps

module dac_instr_queue
	import pid_pkg::*;
	import dac_pkg::*;
(
	input  logic                  clk50,
	input  logic                  reset,
	input  logic                  in_valid,
	input  logic [W_CHAN_SEL-1:0] in_chan,
	input  logic [W_DAC_DATA-1:0] in_code,
	input  logic                  frame_done,
	output logic                  req_valid,
	output logic [W_CHAN_SEL-1:0] req_chan,
	output logic [W_DAC_DATA-1:0] req_code
);

	logic [W_DAC_DATA-1:0] code [N_CHAN];  // newest code per channel
	logic [N_CHAN-1:0]     pend;           // code not yet on the wire
	logic                  renew;          // channel in flight got a newer code
	logic                  pick_valid;
	logic [W_CHAN_SEL-1:0] pick_chan;
	logic [W_CHAN_SEL-1:0] idx;
	logic                  grant;          // hand a new channel to the controller

	// round robin, search starts after the channel served last
	always_comb begin
		pick_valid = 1'b0;
		pick_chan  = req_chan;
		for (int k = 1; k <= N_CHAN; k++) begin
			idx = W_CHAN_SEL'(req_chan + k);
			if (!pick_valid && pend[idx]) begin
				pick_valid = 1'b1;
				pick_chan  = idx;
			end
		end
	end

	assign grant = !req_valid && pick_valid;

	always_ff @(posedge clk50) begin
		if (reset) begin
			pend      <= '0;
			renew     <= 1'b0;
			req_valid <= 1'b0;
			req_chan  <= W_CHAN_SEL'(N_CHAN - 1);  // first pick is channel 0
		end else begin
			for (int i = 0; i < N_CHAN; i++) begin
				if (in_valid && in_chan == W_CHAN_SEL'(i))
					pend[i] <= 1'b1;  // newer value wins over a clear
				else if (frame_done && !renew && req_chan == W_CHAN_SEL'(i))
					pend[i] <= 1'b0;
			end
			if (frame_done) begin
				req_valid <= 1'b0;
				renew     <= 1'b0;
			end else if (req_valid && in_valid && in_chan == req_chan) begin
				renew <= 1'b1;
			end else if (grant) begin
				req_valid <= 1'b1;
				req_chan  <= pick_chan;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (in_valid)
			code[in_chan] <= in_code;
		if (grant)  // bypass a code arriving in the same cycle
			req_code <= (in_valid && in_chan == pick_chan) ? in_code : code[pick_chan];
	end

endmodule

// File: rtl/dac_pkg.sv
package dac_pkg;

	localparam int W_DAC_DATA  = 16;  // unsigned dac code
	localparam int W_DAC_FRAME = 32;  // bits per nsync frame

	localparam logic [3:0] DAC_CMD_WRITE_UPDATE = 4'h3;  // load and update one channel

	////////////////////////////////////////////////////////////
	// serial timing

	localparam int SCLK_DIV   = 1;  // clk50 cycles per half sclk period
	localparam int NSYNC_GAP  = 2;  // min clk50 cycles of nsync high between frames
	localparam int W_DIV_CNT  = $clog2(SCLK_DIV + 1);
	localparam int W_HALF_CNT = $clog2(2 * W_DAC_FRAME);  // half periods in one frame

	////////////////////////////////////////////////////////////
	// one frame, seen as dac8568 fields or as the shift word

	typedef union packed {
		struct packed {
			logic [3:0]            prefix;   // always zero
			logic [3:0]            command;
			logic [3:0]            address;  // dac channel
			logic [W_DAC_DATA-1:0] data;
			logic [3:0]            feature;  // always zero
		} f;
		logic [W_DAC_FRAME-1:0] raw;      // msb goes out first
	} dac_frame_u;

endpackage

// File: rtl/output_preprocessor.sv
`timescale 1ns/1ps

module output_preprocessor
	import pid_pkg::*;
	import dac_pkg::*;
(
	input  logic                     clk50,
	input  logic                     reset,
	input  logic [N_CHAN-1:0]        lock_en,
	input  logic [W_DAC_DATA-1:0]    out_min,
	input  logic [W_DAC_DATA-1:0]    out_max,
	input  logic [W_DAC_DATA-1:0]    out_init,
	input  logic signed [W_COEF-1:0] multiplier,
	input  logic                     in_valid,
	input  logic [W_CHAN_SEL-1:0]    in_chan,
	input  logic signed [W_PID-1:0]  in_data,
	output logic                     out_valid,
	output logic [W_CHAN_SEL-1:0]    out_chan,
	output logic [W_DAC_DATA-1:0]    out_code
);

	logic signed [W_COEF+W_PID-1:0] prod;   // scaled pid output
	logic signed [W_COEF+W_PID:0]   sum;    // offset by the init code
	logic [W_DAC_DATA-1:0]          clamp;

	assign prod = multiplier * in_data;
	assign sum  = $signed({1'b0, out_init}) + prod;

	always_comb begin
		if (!lock_en[in_chan])
			clamp = out_init;  // idle output, no clamp
		else if (sum < $signed({1'b0, out_min}))
			clamp = out_min;
		else if (sum > $signed({1'b0, out_max}))
			clamp = out_max;
		else
			clamp = sum[W_DAC_DATA-1:0];
	end

	always_ff @(posedge clk50) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= in_valid;
	end

	always_ff @(posedge clk50) begin
		if (in_valid) begin
			out_chan <= in_chan;
			out_code <= clamp;
		end
	end

endmodule

// File: rtl/oversample_filter.sv
`timescale 1ns/1ps

module oversample_filter
	import pid_pkg::*;
(
	input  logic                    clk50,
	input  logic                    reset,
	input  logic [W_OSM-1:0]        osm,
	input  logic                    in_valid,
	input  logic [W_CHAN_SEL-1:0]   in_chan,
	input  logic signed [W_ADC-1:0] in_data,
	output logic                    out_valid,
	output logic [W_CHAN_SEL-1:0]   out_chan,
	output logic signed [W_ADC-1:0] out_data
);

	logic signed [W_ACC-1:0] sum [N_CHAN];  // running block sum
	logic [W_OSM:0]          cnt [N_CHAN];  // samples already in the block
	logic signed [W_ACC-1:0] sum_next;      // sum including this sample
	logic [W_OSM:0]          cnt_last;      // index of the closing sample
	logic                    blk_end;

	assign sum_next = sum[in_chan] + W_ACC'(in_data);  // sign extended
	assign cnt_last = (W_OSM+1)'((1 << osm) - 1);
	assign blk_end  = cnt[in_chan] >= cnt_last;  // >= survives an osm change mid block

	always_ff @(posedge clk50) begin
		if (reset) begin
			out_valid <= 1'b0;
			for (int i = 0; i < N_CHAN; i++) begin
				sum[i] <= '0;
				cnt[i] <= '0;
			end
		end else begin
			out_valid <= in_valid && blk_end;
			if (in_valid) begin
				sum[in_chan] <= blk_end ? '0 : sum_next;  // restart after the last sample
				cnt[in_chan] <= blk_end ? '0 : cnt[in_chan] + 1'b1;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (in_valid) begin
			out_chan <= in_chan;
			out_data <= W_ADC'(sum_next >>> osm);  // average, arithmetic shift
		end
	end

	// register file must never hand over more than 16 samples per block
	osm_legal: assert property (@(posedge clk50) disable iff (reset)
		in_valid |-> osm <= W_OSM'(OSM_MAX));

endmodule

// File: rtl/param_regs.sv
`timescale 1ns/1ps

module param_regs
	import pid_pkg::*;
	import dac_pkg::*;
(
	input  logic                     clk50,
	input  logic                     reset,
	input  logic                     wb_cyc,
	input  logic                     wb_stb,
	input  logic                     wb_we,
	input  logic [W_WB_ADR-1:0]      wb_adr,
	input  logic [W_WB_DAT-1:0]      wb_dat_w,
	output logic [W_WB_DAT-1:0]      wb_dat_r,
	output logic                     wb_ack,
	output logic [N_CHAN-1:0]        lock_en,
	output logic [N_CHAN-1:0]        clear,
	output logic [W_OSM-1:0]         osm,
	output logic signed [W_COEF-1:0] setpoint,
	output logic signed [W_COEF-1:0] p_coef,
	output logic signed [W_COEF-1:0] i_coef,
	output logic [W_DAC_DATA-1:0]    out_min,
	output logic [W_DAC_DATA-1:0]    out_max,
	output logic [W_DAC_DATA-1:0]    out_init,
	output logic signed [W_COEF-1:0] multiplier
);

	logic                access;   // strobe seen and not yet acked
	logic [W_WB_DAT-1:0] rd_word;  // readback mux

	assign access = wb_cyc & wb_stb & ~wb_ack;

	////////////////////////////////////////////////////////////
	// ack and register writes

	always_ff @(posedge clk50) begin
		if (reset) begin
			wb_ack     <= 1'b0;
			lock_en    <= '0;
			clear      <= '0;
			osm        <= '0;
			setpoint   <= '0;
			p_coef     <= '0;
			i_coef     <= '0;
			out_min    <= '0;
			out_max    <= '1;  // full dac range
			out_init   <= '0;
			multiplier <= W_COEF'(1);  // unity gain
		end else begin
			wb_ack <= access;  // one cycle, the cycle after the strobe
			clear  <= '0;
			if (access && wb_we) begin
				case (wb_adr)
					REG_CTRL: begin
						lock_en <= wb_dat_w[N_CHAN-1:0];
						clear   <= wb_dat_w[2*N_CHAN-1:N_CHAN];  // pulse, not stored
						osm     <= wb_dat_w[CTRL_OSM_LSB +: W_OSM];
					end
					REG_SETP:  setpoint   <= wb_dat_w[W_COEF-1:0];
					REG_PCOEF: p_coef     <= wb_dat_w[W_COEF-1:0];
					REG_ICOEF: i_coef     <= wb_dat_w[W_COEF-1:0];
					REG_OMIN:  out_min    <= wb_dat_w[W_DAC_DATA-1:0];
					REG_OMAX:  out_max    <= wb_dat_w[W_DAC_DATA-1:0];
					REG_OINIT: out_init   <= wb_dat_w[W_DAC_DATA-1:0];
					REG_MULT:  multiplier <= wb_dat_w[W_COEF-1:0];
				endcase
			end
		end
	end

	////////////////////////////////////////////////////////////
	// readback, zero extended

	always_comb begin
		case (wb_adr)
			REG_CTRL:  rd_word = W_WB_DAT'({osm, {N_CHAN{1'b0}}, lock_en});  // clear reads 0
			REG_SETP:  rd_word = W_WB_DAT'(unsigned'(setpoint));
			REG_PCOEF: rd_word = W_WB_DAT'(unsigned'(p_coef));
			REG_ICOEF: rd_word = W_WB_DAT'(unsigned'(i_coef));
			REG_OMIN:  rd_word = W_WB_DAT'(out_min);
			REG_OMAX:  rd_word = W_WB_DAT'(out_max);
			REG_OINIT: rd_word = W_WB_DAT'(out_init);
			default:   rd_word = W_WB_DAT'(unsigned'(multiplier));
		endcase
	end

	always_ff @(posedge clk50) begin
		if (access)
			wb_dat_r <= rd_word;  // lands together with ack
	end

	// ack only ever answers a live strobe from the master
	ack_needs_stb: assert property (@(posedge clk50) disable iff (reset)
		wb_ack |-> wb_cyc && wb_stb);

endmodule

// File: rtl/pid_controller.sv
`timescale 1ns/1ps

module pid_controller
	import pid_pkg::*;
	import dac_pkg::*;
(
	input  logic                    clk50,
	input  logic                    reset,
	input  logic                    sample_valid,
	input  logic [W_CHAN_SEL-1:0]   sample_chan,
	input  logic signed [W_ADC-1:0] sample_data,
	input  logic                    wb_cyc,
	input  logic                    wb_stb,
	input  logic                    wb_we,
	input  logic [W_WB_ADR-1:0]     wb_adr,
	input  logic [W_WB_DAT-1:0]     wb_dat_w,
	output logic [W_WB_DAT-1:0]     wb_dat_r,
	output logic                    wb_ack,
	output logic                    dac_nsync,
	output logic                    dac_sclk,
	output logic                    dac_din
);

	// loop parameters from the register file
	logic [N_CHAN-1:0]        lock_en;
	logic [N_CHAN-1:0]        clear;
	logic [W_OSM-1:0]         osm;
	logic signed [W_COEF-1:0] setpoint, p_coef, i_coef, multiplier;
	logic [W_DAC_DATA-1:0]    out_min, out_max, out_init;

	// pipeline links, valid is a one cycle pulse
	logic                    osf_valid, pid_valid, opp_valid, req_valid;
	logic [W_CHAN_SEL-1:0]   osf_chan, pid_chan, opp_chan, req_chan;
	logic signed [W_ADC-1:0] osf_data;
	logic signed [W_PID-1:0] pid_data;
	logic [W_DAC_DATA-1:0]   opp_code, req_code;
	logic                    frame_done;  // dac frame finished, queue may move on

	param_regs u_param_regs (
		.clk50, .reset, .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.lock_en, .clear, .osm, .setpoint, .p_coef, .i_coef,
		.out_min, .out_max, .out_init, .multiplier
	);

	oversample_filter u_osf (
		.clk50, .reset, .osm,
		.in_valid  (sample_valid), .in_chan  (sample_chan), .in_data  (sample_data),
		.out_valid (osf_valid),    .out_chan (osf_chan),    .out_data (osf_data)
	);

	pid_core u_pid_core (
		.clk50, .reset, .lock_en, .clear, .setpoint, .p_coef, .i_coef,
		.in_valid  (osf_valid), .in_chan  (osf_chan), .in_data  (osf_data),
		.out_valid (pid_valid), .out_chan (pid_chan), .out_data (pid_data)
	);

	output_preprocessor u_opp (
		.clk50, .reset, .lock_en, .out_min, .out_max, .out_init, .multiplier,
		.in_valid  (pid_valid), .in_chan  (pid_chan), .in_data  (pid_data),
		.out_valid (opp_valid), .out_chan (opp_chan), .out_code (opp_code)
	);

	dac_instr_queue u_diq (
		.clk50, .reset, .frame_done,
		.in_valid (opp_valid), .in_chan (opp_chan), .in_code (opp_code),
		.req_valid, .req_chan, .req_code
	);

	dac_controller u_dac_ctrl (
		.clk50, .reset, .req_valid, .req_chan, .req_code,
		.frame_done, .dac_nsync, .dac_sclk, .dac_din
	);

endmodule

// File: rtl/pid_core.sv
`timescale 1ns/1ps

module pid_core
	import pid_pkg::*;
(
	input  logic                     clk50,
	input  logic                     reset,
	input  logic [N_CHAN-1:0]        lock_en,
	input  logic [N_CHAN-1:0]        clear,
	input  logic signed [W_COEF-1:0] setpoint,
	input  logic signed [W_COEF-1:0] p_coef,
	input  logic signed [W_COEF-1:0] i_coef,
	input  logic                     in_valid,
	input  logic [W_CHAN_SEL-1:0]    in_chan,
	input  logic signed [W_ADC-1:0]  in_data,
	output logic                     out_valid,
	output logic [W_CHAN_SEL-1:0]    out_chan,
	output logic signed [W_PID-1:0]  out_data
);

	logic signed [W_ACC-1:0]        integ [N_CHAN];  // per channel integrator
	logic signed [W_ADC:0]          err;             // one guard bit
	logic signed [W_ACC-1:0]        integ_cur;
	logic signed [W_ACC-1:0]        integ_new;
	logic                           s1_valid;
	logic                           s1_lock;
	logic [W_CHAN_SEL-1:0]          s1_chan;
	logic signed [W_ACC-1:0]        s1_integ;
	logic signed [W_COEF+W_ADC:0]   s1_p;            // p_coef * err
	logic signed [W_COEF+W_ACC-1:0] s1_i;            // i_coef * new integral
	logic signed [W_COEF+W_ACC:0]   s2_sum;
	logic signed [W_COEF+W_ACC:0]   s2_shf;
	logic signed [W_PID-1:0]        s2_sat;

	////////////////////////////////////////////////////////////
	// stage one: error, integral and products

	assign err = (W_ADC+1)'(setpoint) - (W_ADC+1)'(in_data);

	// forward the integral still sitting in stage one for the same channel
	assign integ_cur = clear[in_chan]                   ? '0 :
	                   (s1_valid && s1_chan == in_chan) ? s1_integ : integ[in_chan];
	assign integ_new = lock_en[in_chan] ? integ_cur + W_ACC'(err) : '0;

	always_ff @(posedge clk50) begin
		if (reset)
			s1_valid <= 1'b0;
		else
			s1_valid <= in_valid;
	end

	always_ff @(posedge clk50) begin
		if (in_valid) begin
			s1_chan  <= in_chan;
			s1_lock  <= lock_en[in_chan];
			s1_integ <= integ_new;
			s1_p     <= p_coef * err;
			s1_i     <= i_coef * integ_new;
		end
	end

	////////////////////////////////////////////////////////////
	// stage two: sum, shift, saturate

	assign s2_sum = s1_p + s1_i;
	assign s2_shf = s2_sum >>> COEF_SHIFT;

	always_comb begin
		if (&s2_shf[W_COEF+W_ACC:W_PID-1] || ~|s2_shf[W_COEF+W_ACC:W_PID-1])
			s2_sat = s2_shf[W_PID-1:0];  // fits
		else if (s2_shf[W_COEF+W_ACC])
			s2_sat = {1'b1, {(W_PID-1){1'b0}}};  // negative full scale
		else
			s2_sat = {1'b0, {(W_PID-1){1'b1}}};
	end

	always_ff @(posedge clk50) begin
		if (reset) begin
			out_valid <= 1'b0;
			for (int i = 0; i < N_CHAN; i++)
				integ[i] <= '0;
		end else begin
			out_valid <= s1_valid;
			for (int i = 0; i < N_CHAN; i++) begin
				if (clear[i] || !lock_en[i])
					integ[i] <= '0;  // unlocked channels sit at zero
				else if (s1_valid && s1_chan == W_CHAN_SEL'(i))
					integ[i] <= s1_integ;
			end
		end
	end

	always_ff @(posedge clk50) begin
		if (s1_valid) begin
			out_chan <= s1_chan;
			out_data <= s1_lock ? s2_sat : '0;
		end
	end

endmodule

// File: rtl/pid_pkg.sv
package pid_pkg;

	////////////////////////////////////////////////////////////
	// loop geometry

	localparam int N_CHAN     = 4;   // pid channel n feeds dac channel n
	localparam int W_CHAN_SEL = 2;   // channel number
	localparam int W_ADC      = 18;  // signed sample
	localparam int W_PID      = 18;  // signed pid output
	localparam int W_COEF     = 16;  // setpoint, coefficients and multiplier
	localparam int COEF_SHIFT = 8;   // fractional bits of the coefficient products
	localparam int W_ACC      = 32;  // osf accumulator and integrator
	localparam int W_OSM      = 3;   // oversample mode
	localparam int OSM_MAX    = 4;   // largest legal osm, 16 samples per block

	////////////////////////////////////////////////////////////
	// wishbone register map

	localparam int W_WB_ADR     = 3;
	localparam int W_WB_DAT     = 32;
	localparam int CTRL_OSM_LSB = 8;  // osm field in REG_CTRL

	localparam logic [W_WB_ADR-1:0] REG_CTRL  = 3'd0;  // lock_en 3:0, clear 7:4, osm 10:8
	localparam logic [W_WB_ADR-1:0] REG_SETP  = 3'd1;
	localparam logic [W_WB_ADR-1:0] REG_PCOEF = 3'd2;
	localparam logic [W_WB_ADR-1:0] REG_ICOEF = 3'd3;
	localparam logic [W_WB_ADR-1:0] REG_OMIN  = 3'd4;
	localparam logic [W_WB_ADR-1:0] REG_OMAX  = 3'd5;
	localparam logic [W_WB_ADR-1:0] REG_OINIT = 3'd6;
	localparam logic [W_WB_ADR-1:0] REG_MULT  = 3'd7;

endpackage

// File: verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS   = 100,
	parameter int RESET_CYCLES = 5
) (
	output logic clk50,
	output logic reset
);

	initial begin
		clk50 = 1'b0;
		forever #(PERIOD_NS / 2) clk50 = ~clk50;
	end

	initial begin
		reset = 1'b1;  // synchronous, held over the first edges
		repeat (RESET_CYCLES) @(posedge clk50);
		reset <= 1'b0;
	end

endmodule

// File: verification/tb_pid_controller.sv
`timescale 1ns/1ps

module tb_pid_controller
	import pid_pkg::*;
	import dac_pkg::*;
();

	localparam int FRAME_NS = (2 * W_DAC_FRAME + NSYNC_GAP + 2) * 100;  // one frame plus gap

	logic                    clk50, reset;
	logic                    sample_valid;
	logic [W_CHAN_SEL-1:0]   sample_chan;
	logic signed [W_ADC-1:0] sample_data;
	logic                    wb_cyc, wb_stb, wb_we;
	logic [W_WB_ADR-1:0]     wb_adr;
	logic [W_WB_DAT-1:0]     wb_dat_w, wb_dat_r;
	logic                    wb_ack;
	logic                    dac_nsync, dac_sclk, dac_din;

	int                  seed = 32'h9b4ccc3e;
	logic [W_WB_DAT-1:0] shadow [8];            // last value written per register
	longint              integ_model [N_CHAN];  // reference integrators
	logic [15:0]         last_code [N_CHAN];    // newest decoded code per address
	int                  last_addr;
	int                  frame_count = 0;
	int                  ack_count = 0;
	logic [31:0]         shift_bits;
	int                  frame_bits = 0;
	int                  low_cnt = 0;
	logic [15:0]         exp_code [N_CHAN];
	logic [15:0]         first_code;
	logic [W_WB_DAT-1:0] wr;

	tb_clock_gen #(.PERIOD_NS(100), .RESET_CYCLES(5)) u_clock_gen (.clk50, .reset);

	pid_controller u_pid_controller (
		.clk50, .reset, .sample_valid, .sample_chan, .sample_data,
		.wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack,
		.dac_nsync, .dac_sclk, .dac_din
	);

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("FAIL: see errors above");
		$fatal(1);
	endtask

	////////////////////////////////////////////////////////////
	// reference model, straight from the loop rules

	function automatic logic [15:0] model_code(input int ch, input longint avg);
		longint setp, pc, ic, mult, omin, omax, oinit, err, pid, sum;
		setp  = $signed(shadow[REG_SETP][15:0]);
		pc    = $signed(shadow[REG_PCOEF][15:0]);
		ic    = $signed(shadow[REG_ICOEF][15:0]);
		mult  = $signed(shadow[REG_MULT][15:0]);
		omin  = shadow[REG_OMIN][15:0];
		omax  = shadow[REG_OMAX][15:0];
		oinit = shadow[REG_OINIT][15:0];
		err   = setp - avg;
		if (!shadow[REG_CTRL][ch]) begin
			integ_model[ch] = 0;
			return oinit[15:0];  // idle output, unclamped
		end
		integ_model[ch] += err;
		pid = (pc * err + ic * integ_model[ch]) >>> COEF_SHIFT;
		if (pid > 131071)
			pid = 131071;  // 18 bit saturation
		else if (pid < -131072)
			pid = -131072;
		sum = oinit + mult * pid;
		if (sum < omin)
			sum = omin;
		else if (sum > omax)
			sum = omax;
		return sum[15:0];
	endfunction

	////////////////////////////////////////////////////////////
	// wishbone master

	task automatic wb_access(input logic we, input logic [W_WB_ADR-1:0] adr,
	                         input logic [W_WB_DAT-1:0] dat, output logic [W_WB_DAT-1:0] rdat);
		int acks;
		acks = ack_count;
		@(posedge clk50);
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= dat;
		do @(negedge clk50); while (!wb_ack);
		rdat = wb_dat_r;  // valid together with ack
		@(posedge clk50);
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(negedge clk50);
		assert (ack_count == acks + 1)
			else fail_now($sformatf("[ERROR] wb_ack count: got %h expected %h",
			                        ack_count - acks, 1));
	endtask

	task automatic wb_write(input logic [W_WB_ADR-1:0] adr, input logic [W_WB_DAT-1:0] dat);
		logic [W_WB_DAT-1:0] unused;
		wb_access(1'b1, adr, dat, unused);
		shadow[adr] = dat;
		if (adr == REG_CTRL) begin
			for (int ch = 0; ch < N_CHAN; ch++)
				if (dat[N_CHAN+ch] || !dat[ch])
					integ_model[ch] = 0;  // cleared or unlocked integrator
		end
	endtask

	task automatic wb_check(input logic [W_WB_ADR-1:0] adr, input logic [W_WB_DAT-1:0] exp);
		logic [W_WB_DAT-1:0] got;
		wb_access(1'b0, adr, '0, got);
		assert (got == exp)
			else fail_now($sformatf("[ERROR] wb_dat_r reg %0d: got %h expected %h", adr, got, exp));
	endtask

	////////////////////////////////////////////////////////////
	// samples and frames

	task automatic apply_sample(input int ch, input int data);
		@(posedge clk50);
		sample_valid <= 1'b1;
		sample_chan  <= W_CHAN_SEL'(ch);
		sample_data  <= W_ADC'(data);
		@(posedge clk50);
		sample_valid <= 1'b0;
	endtask

	task automatic wait_frame();
		int target;
		target = frame_count + 1;
		wait (frame_count >= target);
	endtask

	task automatic check_code(input int ch, input logic [15:0] exp);
		assert (last_addr == ch)
			else fail_now($sformatf("[ERROR] dac frame address: got %h expected %h", last_addr, ch));
		assert (last_code[ch] == exp)
			else fail_now($sformatf("[ERROR] dac frame data ch %0d: got %h expected %h",
			                        ch, last_code[ch], exp));
	endtask

	// one sample, one frame, compared against the model
	task automatic sample_and_check(input int ch, input int data);
		logic [15:0] exp;
		exp = model_code(ch, data);
		apply_sample(ch, data);
		wait_frame();
		check_code(ch, exp);
	endtask

	task automatic drain_frames();
		int seen;
		do begin
			seen = frame_count;
			#(3 * FRAME_NS);  // queue idle once no frame shows up for a while
		end while (seen != frame_count);
	endtask

	always @(negedge clk50)
		if (wb_ack)
			ack_count++;

	always @(posedge clk50)
		low_cnt <= dac_nsync ? 0 : low_cnt + 1;

	always @(negedge dac_nsync)
		frame_bits = 0;  // frame opens

	// din is latched by the dac on the falling sclk edge
	always @(negedge dac_sclk) begin
		if (!dac_nsync) begin
			shift_bits = {shift_bits[30:0], dac_din};
			frame_bits++;
		end
	end

	always @(posedge dac_nsync) begin
		dac_frame_u fr;
		if (reset === 1'b0) begin
			fr.raw = shift_bits;
			assert (fr.f.prefix == 4'h0 && fr.f.feature == 4'h0)
				else fail_now($sformatf("[ERROR] dac frame zero fields: got %h expected %h",
				                        {fr.f.prefix, fr.f.feature}, 8'h00));
			assert (fr.f.command == DAC_CMD_WRITE_UPDATE)
				else fail_now($sformatf("[ERROR] dac frame command: got %h expected %h",
				                        fr.f.command, DAC_CMD_WRITE_UPDATE));
			assert (fr.f.address < N_CHAN)
				else fail_now($sformatf("[ERROR] dac frame address: got %h expected below %h",
				                        fr.f.address, N_CHAN));
			last_addr = int'(fr.f.address);
			last_code[fr.f.address[W_CHAN_SEL-1:0]] = fr.f.data;
			frame_count++;
		end
	end

	ack_one_cycle: assert property (@(posedge clk50) disable iff (reset) wb_ack |=> !wb_ack)
		else fail_now("wb_ack stayed high for more than one cycle");
	frame_shape: assert property (@(posedge clk50) disable iff (reset)
		$rose(dac_nsync) |-> frame_bits == W_DAC_FRAME && low_cnt == 2 * W_DAC_FRAME)
		else fail_now("dac frame did not carry 32 bits over 64 clocks");
	nsync_gap: assert property (@(posedge clk50) disable iff (reset)
		$rose(dac_nsync) |=> dac_nsync)
		else fail_now("nsync high gap between frames shorter than two clocks");

	initial begin
		#(400 * FRAME_NS);  // watchdog
		fail_now("timeout: run did not finish within 400 frame times");
	end

	////////////////////////////////////////////////////////////
	// test sequence

	initial begin
		sample_valid = 1'b0;
		sample_chan  = '0;
		sample_data  = '0;
		wb_cyc       = 1'b0;
		wb_stb       = 1'b0;
		wb_we        = 1'b0;
		wb_adr       = '0;
		wb_dat_w     = '0;
		for (int i = 0; i < 8; i++)
			shadow[i] = '0;
		shadow[REG_OMAX] = 32'h0000_FFFF;
		shadow[REG_MULT] = 32'h0000_0001;
		for (int i = 0; i < N_CHAN; i++)
			integ_model[i] = 0;
		wait (reset === 1'b0);
		@(posedge clk50);

		// 1: reset values, then write and read back every register
		wb_check(REG_OMAX, 32'h0000_FFFF);
		wb_check(REG_MULT, 32'h0000_0001);
		for (int a = 0; a < 8; a++) begin
			wr = $random(seed);
			wb_write(W_WB_ADR'(a), wr);
			wb_check(W_WB_ADR'(a), (a == 0) ? (wr & 32'h0000_070F) : (wr & 32'h0000_FFFF));
		end

		// 2: unlocked channels send out_init
		wb_write(REG_CTRL, 32'h0);
		wb_write(REG_OMIN, 32'h0);
		wb_write(REG_OMAX, 32'hFFFF);
		wb_write(REG_MULT, 32'h1);
		wb_write(REG_OINIT, 32'h1234);
		wb_write(REG_SETP, 32'h0);
		wb_write(REG_PCOEF, 32'h0);
		wb_write(REG_ICOEF, 32'h0);
		for (int ch = 0; ch < N_CHAN; ch++)
			sample_and_check(ch, $random(seed) % 50000);

		// 3: proportional path on random samples
		wb_write(REG_OINIT, 32'h8000);
		wb_write(REG_PCOEF, 32'd300);
		wb_write(REG_SETP, 32'($random(seed) % 8000));
		wb_write(REG_CTRL, 32'h00F);
		for (int n = 0; n < 8; n++)
			sample_and_check($unsigned($random(seed)) % N_CHAN, $random(seed) % 20000);

		// 4: osm 2, four samples give one averaged frame
		wb_write(REG_PCOEF, 32'd256);
		wb_write(REG_CTRL, 32'h20F);
		begin
			int s [4];
			int total;
			total = 0;
			for (int n = 0; n < 4; n++) begin
				s[n] = $random(seed) % 10000;
				total += s[n];
			end
			exp_code[1] = model_code(1, total >>> 2);
			for (int n = 0; n < 4; n++)
				apply_sample(1, s[n]);
			wait_frame();
			check_code(1, exp_code[1]);
		end
		wb_write(REG_CTRL, 32'h00F);

		// 5: integral growth, then clear back to the first step
		wb_write(REG_PCOEF, 32'h0);
		wb_write(REG_ICOEF, 32'd64);
		wb_write(REG_SETP, 32'd1000);
		wb_write(REG_OINIT, 32'd1000);
		wb_write(REG_MULT, 32'd2);
		wb_write(REG_CTRL, 32'h044);  // only ch2 locked, starting from an empty integrator
		sample_and_check(2, 900);
		first_code = last_code[2];
		sample_and_check(2, 900);
		sample_and_check(2, 900);
		wb_write(REG_CTRL, 32'h044);  // clear ch2, keep it locked
		sample_and_check(2, 900);
		assert (last_code[2] == first_code)
			else fail_now($sformatf("[ERROR] dac frame data after clear: got %h expected %h",
			                        last_code[2], first_code));

		// 6: clamping, then a burst on all channels
		wb_write(REG_ICOEF, 32'h0);
		wb_write(REG_PCOEF, 32'h7FFF);
		wb_write(REG_SETP, 32'h0);
		wb_write(REG_OMIN, 32'd1000);
		wb_write(REG_OMAX, 32'd60000);
		wb_write(REG_OINIT, 32'd30000);
		wb_write(REG_MULT, 32'h1);
		wb_write(REG_CTRL, 32'h00F);
		sample_and_check(0, 100000);   // large negative error, floor
		check_code(0, 16'd1000);
		sample_and_check(1, -100000);  // large positive error, ceiling
		check_code(1, 16'd60000);
		wb_write(REG_PCOEF, 32'd20);
		for (int r = 0; r < 3; r++) begin
			for (int ch = 0; ch < N_CHAN; ch++) begin
				int d;
				d = $random(seed) % 100000;
				exp_code[ch] = model_code(ch, d);
				@(posedge clk50);
				sample_valid <= 1'b1;
				sample_chan  <= W_CHAN_SEL'(ch);
				sample_data  <= W_ADC'(d);
			end
		end
		@(posedge clk50);
		sample_valid <= 1'b0;
		drain_frames();
		for (int ch = 0; ch < N_CHAN; ch++)
			assert (last_code[ch] == exp_code[ch])
				else fail_now($sformatf("[ERROR] dac frame data burst ch %0d: got %h expected %h",
				                        ch, last_code[ch], exp_code[ch]));

		$display("PASS: all tests");
		$finish;
	end

endmodule
